/* design/icache_pkg.sv */
package icache_pkg;

    // physical byte address
    typedef logic [31:0] addr_t;

    // one instruction, also one memory beat
    typedef logic [31:0] word_t;

    // aligned instruction pair, lower address in the low half
    typedef logic [2*$bits(word_t)-1:0] pair_t;

    typedef word_t mem_data_t;

    // block of eight words, 32 bytes
    localparam int unsigned BLOCK_WORDS = 8;
    localparam int unsigned OFFSET_BITS = 5;

    // controller states
    typedef enum logic [2:0] {
        // hits and invalidates flow through
        S_RUN,
        // waiting for the memory credit
        S_MISS_REQ,
        // beats arriving, data store being written
        S_MISS_FILL,
        // victim tag written, toggle flipped
        S_TAG_WRITE,
        // stage B read again from the arrays
        S_REPLAY
    } ctrl_state_t;

endpackage

/* design/tag_store.sv */
module tag_store #(
    parameter  int unsigned SET_NUM    = 64,
    localparam int unsigned INDEX_BITS = $clog2(SET_NUM),
    localparam int unsigned TAG_BITS   = 32 - icache_pkg::OFFSET_BITS - INDEX_BITS
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rd_en_i,
    input  logic [INDEX_BITS-1:0] rd_index_i,
    input  logic [TAG_BITS-1:0]   cmp_tag_i,
    input  logic [1:0]            we_i,
    input  logic [INDEX_BITS-1:0] wr_index_i,
    input  logic [TAG_BITS-1:0]   wr_tag_i,
    input  logic                  wr_valid_i,
    output logic [1:0]            hit_o
);

    typedef logic [TAG_BITS-1:0] tag_t;

    tag_t                    tag_mem [2][SET_NUM];
    logic [1:0][SET_NUM-1:0] valid_q;
    tag_t                    rd_tag_q [2];
    logic [1:0]              rd_valid_q;

    // valid bits per way and set
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q    <= '0;
            rd_valid_q <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (we_i[w]) begin
                    valid_q[w][wr_index_i] <= wr_valid_i;
                end
                if (rd_en_i) begin
                    rd_valid_q[w] <= valid_q[w][rd_index_i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (we_i[w]) begin
                tag_mem[w][wr_index_i] <= wr_tag_i;
            end
            if (rd_en_i) begin
                rd_tag_q[w] <= tag_mem[w][rd_index_i];
            end
        end
    end

    // compare against the stage B tag
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit_o[w] = rd_valid_q[w] && (rd_tag_q[w] == cmp_tag_i);
        end
    end

endmodule

/* design/data_store.sv */
module data_store #(
    parameter  int unsigned SET_NUM    = 64,
    localparam int unsigned INDEX_BITS = $clog2(SET_NUM),
    localparam int unsigned PAIR_BITS  = $clog2(icache_pkg::BLOCK_WORDS / 2)
) (
    input  logic                  clk,
    input  logic                  rd_en_i,
    input  logic [INDEX_BITS-1:0] rd_index_i,
    input  logic [PAIR_BITS-1:0]  rd_pair_i,
    input  logic [1:0]            hit_i,
    input  logic [1:0]            we_i,
    input  logic [INDEX_BITS-1:0] wr_index_i,
    input  logic [PAIR_BITS-1:0]  wr_pair_i,
    input  icache_pkg::pair_t     wr_data_i,
    output icache_pkg::pair_t     rdata_o
);

    localparam int unsigned DEPTH = SET_NUM * (icache_pkg::BLOCK_WORDS / 2);

    // set index on top, pair within the block below
    typedef logic [INDEX_BITS+PAIR_BITS-1:0] line_addr_t;

    icache_pkg::pair_t mem [2][DEPTH];
    icache_pkg::pair_t rd_q [2];
    line_addr_t        rd_addr;
    line_addr_t        wr_addr;

    assign rd_addr = {rd_index_i, rd_pair_i};
    assign wr_addr = {wr_index_i, wr_pair_i};

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (we_i[w]) begin
                mem[w][wr_addr] <= wr_data_i;
            end
            if (rd_en_i) begin
                rd_q[w] <= mem[w][rd_addr];
            end
        end
    end

    // way 0 when nothing hits, the controller ignores it then
    assign rdata_o = hit_i[1] ? rd_q[1] : rd_q[0];

endmodule

/* design/refill_assembler.sv */
module refill_assembler #(
    parameter  int unsigned SET_NUM    = 64,
    localparam int unsigned INDEX_BITS = $clog2(SET_NUM),
    localparam int unsigned PAIR_BITS  = $clog2(icache_pkg::BLOCK_WORDS / 2),
    localparam int unsigned BEAT_BITS  = $clog2(icache_pkg::BLOCK_WORDS)
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start_i,
    input  logic [1:0]            way_i,
    input  logic [INDEX_BITS-1:0] index_i,
    input  logic                  mem_rvalid_i,
    input  icache_pkg::mem_data_t mem_rdata_i,
    output logic [1:0]            we_o,
    output logic [INDEX_BITS-1:0] wr_index_o,
    output logic [PAIR_BITS-1:0]  wr_pair_o,
    output icache_pkg::pair_t     wr_data_o,
    output logic                  done_o
);

    typedef logic [BEAT_BITS-1:0] beat_t;

    localparam beat_t LAST_BEAT = beat_t'(icache_pkg::BLOCK_WORDS - 1);

    beat_t                 beat_q;
    logic [1:0]            way_q;
    logic [INDEX_BITS-1:0] index_q;
    icache_pkg::word_t     even_q;

    // beat counter, wraps back to zero after a full block
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_q <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= mem_rvalid_i && (beat_q == LAST_BEAT);
            if (start_i) begin
                beat_q <= '0;
            end else if (mem_rvalid_i) begin
                beat_q <= beat_q + beat_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            way_q   <= way_i;
            index_q <= index_i;
        end
        // hold the even word until its partner arrives
        if (mem_rvalid_i && !beat_q[0]) begin
            even_q <= mem_rdata_i;
        end
    end

    assign we_o       = (mem_rvalid_i && beat_q[0]) ? way_q : 2'b00;
    assign wr_index_o = index_q;
    assign wr_pair_o  = beat_q[1 +: PAIR_BITS];
    assign wr_data_o  = {mem_rdata_i, even_q};

endmodule

/* design/icache_ctrl.sv */
module icache_ctrl #(
    parameter  int unsigned SET_NUM       = 64,
    parameter  int unsigned FETCH_CREDITS = 2,
    localparam int unsigned INDEX_BITS    = $clog2(SET_NUM),
    localparam int unsigned TAG_BITS      = 32 - icache_pkg::OFFSET_BITS - INDEX_BITS,
    localparam int unsigned PAIR_BITS     = $clog2(icache_pkg::BLOCK_WORDS / 2)
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid_i,
    input  logic                  req_inv_i,
    input  icache_pkg::addr_t     req_addr_i,
    input  logic [1:0]            hit_way_i,
    input  icache_pkg::pair_t     rdata_pair_i,
    input  logic                  fill_done_i,
    input  logic                  mem_credit_i,
    output logic                  rd_en_o,
    output logic [INDEX_BITS-1:0] rd_index_o,
    output logic [PAIR_BITS-1:0]  rd_pair_o,
    output logic [1:0]            tag_we_o,
    output logic [INDEX_BITS-1:0] tag_index_o,
    output logic [TAG_BITS-1:0]   tag_o,
    output logic                  tag_valid_o,
    output logic [1:0]            fill_way_o,
    output logic                  fill_start_o,
    output logic                  mem_req_valid_o,
    output icache_pkg::addr_t     mem_req_addr_o,
    output logic                  credit_o,
    output logic                  resp_valid_o,
    output icache_pkg::pair_t     resp_data_o
);

    localparam int unsigned CRED_BITS = $clog2(FETCH_CREDITS + 1);
    localparam int unsigned PAIR_LSB  = icache_pkg::OFFSET_BITS - PAIR_BITS;

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [CRED_BITS-1:0]  cred_t;

    localparam cred_t CRED_MAX = cred_t'(FETCH_CREDITS);

    icache_pkg::ctrl_state_t state_q;
    icache_pkg::ctrl_state_t state_d;

    // stage A request as sampled
    logic              a_valid_q;
    logic              a_inv_q;
    icache_pkg::addr_t a_addr_q;
    // stage B request under hit decision
    logic              b_valid_q;
    logic              b_inv_q;
    icache_pkg::addr_t b_addr_q;

    logic               mem_credit_q;
    logic [SET_NUM-1:0] toggle_q;
    cred_t              pending_q;

    index_t a_index;
    index_t b_index;
    logic   running;
    logic   replay;
    logic   b_hit;
    logic   b_miss;
    logic   b_inv_go;
    logic   b_done;
    logic   a_adv;
    logic   req_take;
    logic   mem_fire;
    logic   victim;

    assign a_index  = a_addr_q[icache_pkg::OFFSET_BITS +: INDEX_BITS];
    assign b_index  = b_addr_q[icache_pkg::OFFSET_BITS +: INDEX_BITS];
    assign running  = (state_q == icache_pkg::S_RUN);
    assign replay   = (state_q == icache_pkg::S_REPLAY);

    // hit decision on the registered array read
    assign b_hit    = running && b_valid_q && !b_inv_q && (|hit_way_i);
    assign b_miss   = running && b_valid_q && !b_inv_q && !(|hit_way_i);
    assign b_inv_go = running && b_valid_q && b_inv_q;
    assign b_done   = b_hit || b_inv_go;

    // A moves on only when B is empty or leaving without a tag write;
    // after an invalidate A waits a cycle and is read against the new tags
    assign a_adv    = running && (!b_valid_q || b_hit);
    assign req_take = req_valid_i && (pending_q < CRED_MAX) && (a_adv || !a_valid_q);
    assign mem_fire = (state_q == icache_pkg::S_MISS_REQ) && mem_credit_q;
    assign victim   = toggle_q[b_index];

    assign rd_en_o    = (a_adv && a_valid_q) || replay;
    assign rd_index_o = replay ? b_index : a_index;
    assign rd_pair_o  = replay ? b_addr_q[PAIR_LSB +: PAIR_BITS] : a_addr_q[PAIR_LSB +: PAIR_BITS];

    // stage B tag feeds both the compare and the write port
    assign tag_index_o = b_index;
    assign tag_o       = b_addr_q[icache_pkg::OFFSET_BITS + INDEX_BITS +: TAG_BITS];
    assign tag_valid_o = (state_q == icache_pkg::S_TAG_WRITE);
    assign tag_we_o    = b_inv_go ? 2'b11 : (tag_valid_o ? fill_way_o : 2'b00);

    assign fill_way_o      = victim ? 2'b10 : 2'b01;
    assign fill_start_o    = mem_fire;
    assign mem_req_valid_o = mem_fire;
    assign mem_req_addr_o  = {b_addr_q[31:icache_pkg::OFFSET_BITS],
                              {icache_pkg::OFFSET_BITS{1'b0}}};

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::S_RUN: begin
                if (b_miss) begin
                    state_d = icache_pkg::S_MISS_REQ;
                end
            end
            icache_pkg::S_MISS_REQ: begin
                if (mem_credit_q) begin
                    state_d = icache_pkg::S_MISS_FILL;
                end
            end
            icache_pkg::S_MISS_FILL: begin
                if (fill_done_i) begin
                    state_d = icache_pkg::S_TAG_WRITE;
                end
            end
            icache_pkg::S_TAG_WRITE: begin
                state_d = icache_pkg::S_REPLAY;
            end
            default: begin
                state_d = icache_pkg::S_RUN;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q      <= icache_pkg::S_RUN;
            a_valid_q    <= 1'b0;
            b_valid_q    <= 1'b0;
            mem_credit_q <= 1'b1;
            toggle_q     <= '0;
            pending_q    <= '0;
            resp_valid_o <= 1'b0;
            credit_o     <= 1'b0;
        end else begin
            state_q      <= state_d;
            resp_valid_o <= b_hit;
            credit_o     <= b_done;
            pending_q    <= pending_q + cred_t'(req_take) - cred_t'(b_done);
            if (a_adv || !a_valid_q) begin
                a_valid_q <= req_take;
            end
            if (a_adv) begin
                b_valid_q <= a_valid_q;
            end else if (b_done) begin
                b_valid_q <= 1'b0;
            end
            // memory holds a single credit
            if (mem_credit_i) begin
                mem_credit_q <= 1'b1;
            end else if (mem_fire) begin
                mem_credit_q <= 1'b0;
            end
            if (tag_valid_o) begin
                toggle_q[b_index] <= !victim;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (a_adv || !a_valid_q) begin
            a_inv_q  <= req_inv_i;
            a_addr_q <= req_addr_i;
        end
        if (a_adv) begin
            b_inv_q  <= a_inv_q;
            b_addr_q <= a_addr_q;
        end
        if (b_hit) begin
            resp_data_o <= rdata_pair_i;
        end
    end

endmodule

/* design/icache_top.sv */
module icache_top #(
    parameter int unsigned SET_NUM       = 64,
    parameter int unsigned FETCH_CREDITS = 2
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid_i,
    input  logic                  req_inv_i,
    input  icache_pkg::addr_t     req_addr_i,
    output logic                  credit_o,
    output logic                  resp_valid_o,
    output icache_pkg::pair_t     resp_data_o,
    output logic                  mem_req_valid_o,
    output icache_pkg::addr_t     mem_req_addr_o,
    input  logic                  mem_credit_i,
    input  logic                  mem_rvalid_i,
    input  icache_pkg::mem_data_t mem_rdata_i
);

    localparam int unsigned INDEX_BITS = $clog2(SET_NUM);
    localparam int unsigned TAG_BITS   = 32 - icache_pkg::OFFSET_BITS - INDEX_BITS;
    localparam int unsigned PAIR_BITS  = $clog2(icache_pkg::BLOCK_WORDS / 2);

    // array read side
    logic                  rd_en;
    logic [INDEX_BITS-1:0] rd_index;
    logic [PAIR_BITS-1:0]  rd_pair;
    logic [1:0]            hit_way;
    icache_pkg::pair_t     rdata_pair;

    // tag write side, index and tag also serve the hit compare and refill
    logic [1:0]            tag_we;
    logic [INDEX_BITS-1:0] tag_index;
    logic [TAG_BITS-1:0]   tag_wr;
    logic                  tag_valid;

    // refill path
    logic [1:0]            fill_way;
    logic                  fill_start;
    logic                  fill_done;
    logic [1:0]            refill_we;
    logic [INDEX_BITS-1:0] refill_index;
    logic [PAIR_BITS-1:0]  refill_pair;
    icache_pkg::pair_t     refill_data;

    icache_ctrl #(
        .SET_NUM       (SET_NUM),
        .FETCH_CREDITS (FETCH_CREDITS)
    ) u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_valid_i     (req_valid_i),
        .req_inv_i       (req_inv_i),
        .req_addr_i      (req_addr_i),
        .hit_way_i       (hit_way),
        .rdata_pair_i    (rdata_pair),
        .fill_done_i     (fill_done),
        .mem_credit_i    (mem_credit_i),
        .rd_en_o         (rd_en),
        .rd_index_o      (rd_index),
        .rd_pair_o       (rd_pair),
        .tag_we_o        (tag_we),
        .tag_index_o     (tag_index),
        .tag_o           (tag_wr),
        .tag_valid_o     (tag_valid),
        .fill_way_o      (fill_way),
        .fill_start_o    (fill_start),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .credit_o        (credit_o),
        .resp_valid_o    (resp_valid_o),
        .resp_data_o     (resp_data_o)
    );

    tag_store #(.SET_NUM(SET_NUM)) u_tag_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_en_i    (rd_en),
        .rd_index_i (rd_index),
        .cmp_tag_i  (tag_wr),
        .we_i       (tag_we),
        .wr_index_i (tag_index),
        .wr_tag_i   (tag_wr),
        .wr_valid_i (tag_valid),
        .hit_o      (hit_way)
    );

    data_store #(.SET_NUM(SET_NUM)) u_data_store (
        .clk        (clk),
        .rd_en_i    (rd_en),
        .rd_index_i (rd_index),
        .rd_pair_i  (rd_pair),
        .hit_i      (hit_way),
        .we_i       (refill_we),
        .wr_index_i (refill_index),
        .wr_pair_i  (refill_pair),
        .wr_data_i  (refill_data),
        .rdata_o    (rdata_pair)
    );

    refill_assembler #(.SET_NUM(SET_NUM)) u_refill (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (fill_start),
        .way_i        (fill_way),
        .index_i      (tag_index),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .we_o         (refill_we),
        .wr_index_o   (refill_index),
        .wr_pair_o    (refill_pair),
        .wr_data_o    (refill_data),
        .done_o       (fill_done)
    );

endmodule

/* bench/icache_asserts.sv */
module icache_asserts #(
    parameter  int unsigned FETCH_CREDITS = 2,
    localparam int unsigned CNT_BITS      = $clog2(FETCH_CREDITS + 2)
) (
    input logic clk,
    input logic rst_n,
    input logic req_valid_i,
    input logic credit_i,
    input logic mem_credit_i,
    input logic mem_req_valid_i,
    input logic fill_start_i,
    input logic fill_done_i
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef logic [CNT_BITS-1:0] cnt_t;

    localparam cnt_t CRED_MAX = cnt_t'(FETCH_CREDITS);

    // requests spent minus credits returned at the ports
    cnt_t outstanding_q;
    // the single memory credit as seen on the memory side
    logic mem_credit_q;
    // open from the memory request until the done pulse
    logic fill_open;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            outstanding_q <= '0;
            mem_credit_q  <= 1'b1;
            fill_open     <= 1'b0;
        end else begin
            outstanding_q <= outstanding_q + cnt_t'(req_valid_i) - cnt_t'(credit_i);
            if (mem_credit_i) begin
                mem_credit_q <= 1'b1;
            end else if (mem_req_valid_i) begin
                mem_credit_q <= 1'b0;
            end
            if (fill_start_i) begin
                fill_open <= 1'b1;
            end else if (fill_done_i) begin
                fill_open <= 1'b0;
            end
        end
    end

    credits_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding_q <= CRED_MAX)
        else $error("more requests in flight than fetch credits");

    mem_req_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid_i |-> mem_credit_q)
        else $error("memory request issued without the memory credit");

    done_after_request: assert property (@(posedge clk) disable iff (!rst_n)
        fill_done_i |-> fill_open)
        else $error("refill done without a memory request");

endmodule

/* bench/mem_model.sv */
module mem_model (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid_i,
    input  icache_pkg::addr_t     req_addr_i,
    output logic                  rvalid_o,
    output icache_pkg::mem_data_t rdata_o,
    output logic                  credit_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] lfsr = 32'h10a2a693;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // memory contents as a function of the whole address
    function automatic icache_pkg::word_t word_at(input icache_pkg::addr_t a);
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
    endfunction

    initial begin
        icache_pkg::addr_t base;
        int delay;
        rvalid_o = 1'b0;
        rdata_o  = '0;
        credit_o = 1'b0;
        @(negedge clk);
        forever begin
            if (rst_n && req_valid_i) begin
                base  = req_addr_i;
                delay = int'(take_bits(3));
                repeat (delay + 1) @(negedge clk);
                for (int beat = 0; beat < icache_pkg::BLOCK_WORDS; beat++) begin
                    rvalid_o = 1'b1;
                    rdata_o  = word_at(base + icache_pkg::addr_t'(4 * beat));
                    @(negedge clk);
                    rvalid_o = 1'b0;
                    // occasional idle cycle between beats
                    if (take_bits(1) == 1) begin
                        @(negedge clk);
                    end
                end
                credit_o = 1'b1;
                @(negedge clk);
                credit_o = 1'b0;
            end else begin
                @(negedge clk);
            end
        end
    end

endmodule

/* bench/icache_tb.sv */
module icache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned SET_NUM       = 64;
    localparam int unsigned FETCH_CREDITS = 2;
    localparam int unsigned INDEX_BITS    = $clog2(SET_NUM);
    localparam int          NUM_RANDOM    = 300;
    // directed requests plus the random mix
    localparam int          NUM_REQ       = 20 + NUM_RANDOM;
    // delay, beats with gaps, tag write and replay
    localparam int          MISS_CYCLES   = 48;
    localparam int          LIMIT         = 10 * NUM_REQ * MISS_CYCLES;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  req_valid_i;
    logic                  req_inv_i;
    icache_pkg::addr_t     req_addr_i;
    logic                  credit_o;
    logic                  resp_valid_o;
    icache_pkg::pair_t     resp_data_o;
    logic                  mem_req_valid;
    icache_pkg::addr_t     mem_req_addr;
    logic                  mem_credit;
    logic                  mem_rvalid;
    icache_pkg::mem_data_t mem_rdata;

    logic [31:0]       lfsr = 32'h10a2a693;
    logic              sh_valid [2][SET_NUM];
    logic [31:0]       sh_tag [2][SET_NUM];
    logic              sh_toggle [SET_NUM];
    icache_pkg::pair_t exp_pairs [$];
    icache_pkg::addr_t exp_addrs [$];
    int                sent = 0;
    int                returned = 0;
    int                cycles = 0;
    string             test_name = "reset";

    always #2 clk = ~clk;

    icache_top #(
        .SET_NUM       (SET_NUM),
        .FETCH_CREDITS (FETCH_CREDITS)
    ) UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_valid_i     (req_valid_i),
        .req_inv_i       (req_inv_i),
        .req_addr_i      (req_addr_i),
        .credit_o        (credit_o),
        .resp_valid_o    (resp_valid_o),
        .resp_data_o     (resp_data_o),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_addr_o  (mem_req_addr),
        .mem_credit_i    (mem_credit),
        .mem_rvalid_i    (mem_rvalid),
        .mem_rdata_i     (mem_rdata)
    );

    mem_model u_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (mem_req_valid),
        .req_addr_i  (mem_req_addr),
        .rvalid_o    (mem_rvalid),
        .rdata_o     (mem_rdata),
        .credit_o    (mem_credit)
    );

    bind icache_ctrl icache_asserts #(.FETCH_CREDITS(FETCH_CREDITS)) u_asserts (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_valid_i     (req_valid_i),
        .credit_i        (credit_o),
        .mem_credit_i    (mem_credit_i),
        .mem_req_valid_i (mem_req_valid_o),
        .fill_start_i    (fill_start_o),
        .fill_done_i     (fill_done_i)
    );

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic icache_pkg::word_t word_at(input icache_pkg::addr_t a);
        return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
    endfunction

    // reference pair with the lower word in the low half
    function automatic icache_pkg::pair_t expected_pair(input icache_pkg::addr_t a);
        return {word_at(a + 32'd4), word_at(a)};
    endfunction

    function automatic icache_pkg::addr_t make_addr(input int unsigned tag,
                                                    input int unsigned idx,
                                                    input int unsigned pair);
        return icache_pkg::addr_t'((tag << (5 + INDEX_BITS)) | (idx << 5) | (pair << 3));
    endfunction

    // shadow tags predict hits, misses and victims in request order
    function automatic void predict(input logic inv, input icache_pkg::addr_t a);
        logic [INDEX_BITS-1:0] idx;
        logic [31:0]           tag;
        logic                  victim;
        logic                  hit;
        idx = a[icache_pkg::OFFSET_BITS +: INDEX_BITS];
        tag = a >> (icache_pkg::OFFSET_BITS + INDEX_BITS);
        if (inv) begin
            sh_valid[0][idx] = 1'b0;
            sh_valid[1][idx] = 1'b0;
        end else begin
            exp_pairs.push_back(expected_pair(a));
            hit = (sh_valid[0][idx] && sh_tag[0][idx] == tag)
               || (sh_valid[1][idx] && sh_tag[1][idx] == tag);
            if (!hit) begin
                exp_addrs.push_back(a & 32'hffff_ffe0);
                victim = sh_toggle[idx];
                sh_tag[victim][idx]   = tag;
                sh_valid[victim][idx] = 1'b1;
                sh_toggle[idx]        = !victim;
            end
        end
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_pair(input string name, input icache_pkg::pair_t exp,
                              input icache_pkg::pair_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input icache_pkg::addr_t exp,
                              input icache_pkg::addr_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
        end
    endtask

    // called on a falling edge and waits for a free credit
    task automatic send(input logic inv, input icache_pkg::addr_t a, input int gap);
        while (sent - returned >= int'(FETCH_CREDITS)) begin
            @(negedge clk);
        end
        req_valid_i = 1'b1;
        req_inv_i   = inv;
        req_addr_i  = a;
        predict(inv, a);
        sent++;
        @(negedge clk);
        req_valid_i = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic drain();
        while (returned != sent || exp_pairs.size() != 0 || exp_addrs.size() != 0) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && credit_o) begin
            returned <= returned + 1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            fail_run($sformatf("timeout in test %s after %0d cycles", test_name, cycles));
        end
    end

    // responses and memory requests in order
    always @(negedge clk) begin
        if (rst_n) begin
            if (resp_valid_o) begin
                if (exp_pairs.size() == 0) begin
                    fail_run($sformatf("response without a pending fetch in %s", test_name));
                end else begin
                    check_pair(test_name, exp_pairs.pop_front(), resp_data_o);
                end
                if (!credit_o) begin
                    fail_run($sformatf("response without its credit return in %s",
                                       test_name));
                end
            end
            if (mem_req_valid) begin
                if (exp_addrs.size() == 0) begin
                    fail_run($sformatf("unexpected memory request in %s", test_name));
                end else begin
                    check_addr(test_name, exp_addrs.pop_front(), mem_req_addr);
                end
            end
            if (returned > sent) begin
                fail_run($sformatf("more credits returned than requests in %s", test_name));
            end
        end
    end

    initial begin
        logic              inv;
        int unsigned       t;
        int unsigned       i;
        int unsigned       p;
        int                gap;
        for (int s = 0; s < int'(SET_NUM); s++) begin
            sh_valid[0][s] = 1'b0;
            sh_valid[1][s] = 1'b0;
            sh_tag[0][s]   = '0;
            sh_tag[1][s]   = '0;
            sh_toggle[s]   = 1'b0;
        end
        req_valid_i = 1'b0;
        req_inv_i   = 1'b0;
        req_addr_i  = '0;
        rst_n       = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        repeat (4) begin
            @(negedge clk);
            if (resp_valid_o || credit_o || mem_req_valid) begin
                fail_run("outputs active after reset with no request");
            end
        end

        test_name = "first_fetch";
        send(1'b0, make_addr(1, 2, 1), 0);
        drain();

        test_name = "same_block";
        send(1'b0, make_addr(1, 2, 3), 0);
        drain();

        // three blocks in set 5 fill the ways in toggle order
        test_name = "set_conflict";
        send(1'b0, make_addr(1, 5, 0), 1);
        send(1'b0, make_addr(2, 5, 1), 1);
        send(1'b0, make_addr(3, 5, 2), 1);
        send(1'b0, make_addr(2, 5, 3), 1);
        send(1'b0, make_addr(1, 5, 0), 1);
        send(1'b0, make_addr(3, 5, 1), 1);
        send(1'b0, make_addr(2, 5, 2), 1);
        drain();

        test_name = "invalidate";
        send(1'b1, make_addr(7, 5, 0), 0);
        send(1'b0, make_addr(2, 5, 0), 0);
        send(1'b0, make_addr(1, 5, 1), 0);
        drain();

        test_name = "back_to_back";
        send(1'b0, make_addr(4, 9, 0), 0);
        send(1'b0, make_addr(4, 9, 1), 0);
        send(1'b0, make_addr(4, 9, 2), 0);
        send(1'b0, make_addr(4, 9, 3), 0);
        send(1'b1, make_addr(4, 9, 0), 0);
        send(1'b0, make_addr(4, 9, 1), 0);
        send(1'b0, make_addr(5, 11, 0), 0);
        send(1'b0, make_addr(6, 12, 2), 0);
        drain();

        test_name = "random_mix";
        repeat (NUM_RANDOM) begin
            inv = (take_bits(4) == 0);
            t   = take_bits(2) + 1;
            i   = take_bits(3) + 8;
            p   = take_bits(2);
            gap = int'(take_bits(2)) * int'(take_bits(1));
            send(inv, make_addr(t, i, p), gap);
        end
        drain();

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* icache_top.f */
design/icache_pkg.sv
design/tag_store.sv
design/data_store.sv
design/refill_assembler.sv
design/icache_ctrl.sv
design/icache_top.sv
bench/icache_asserts.sv
bench/mem_model.sv
bench/icache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module icache_tb -f icache_top.f \
    --Mdir obj_dir -o icache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/icache_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1
